//--- logic/conv_pkg.sv
// ****************************************
// conv tile engine shared types
// ****************************************

package conv_pkg;

    typedef logic signed [15:0] word_t;  // feature and weight data
    typedef logic        [15:0] addr_t;  // word address into any tile memory
    typedef logic signed [31:0] acc_t;   // mac accumulator

    // which tile a loader walks
    typedef enum logic [1:0] {
        LOAD_IN_FM,
        LOAD_WEIGHT,
        LOAD_OUT_FM
    } load_kind_e;

    // compute core control
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        COMPUTE,
        DRAIN
    } core_state_e;

endpackage

//--- logic/sync_fifo.sv
// ****************************************
// small synchronous fifo
// ****************************************
`timescale 1ns/100ps

module sync_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            push,
    input  conv_pkg::word_t din,
    input  logic            pop,
    output conv_pkg::word_t dout,
    output logic            almost_full,
    output logic            empty
);
    import conv_pkg::*;

    localparam int PW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    word_t         mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= din;
    end

    assign dout        = mem[rd_ptr];  // show-ahead read
    assign empty       = (count == '0);
    assign almost_full = (count >= CW'(FIFO_DEPTH - 1));  // one slot kept for the word in flight

    // producer and consumer must honour the flags
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        !(push && count == CW'(FIFO_DEPTH)) && !(pop && empty))
        else $error("fifo pushed when full or popped when empty");

endmodule

//--- logic/tile_loader.sv
// ****************************************
// tile read port walker
// ****************************************
`timescale 1ns/100ps

module tile_loader #(
    parameter conv_pkg::load_kind_e KIND = conv_pkg::LOAD_IN_FM,
    parameter int N  = 4,
    parameter int M  = 4,
    parameter int R  = 8,
    parameter int C  = 8,
    parameter int Tn = 2,
    parameter int Tm = 2,
    parameter int Tr = 4,
    parameter int Tc = 4,
    parameter int K  = 3
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    output logic            done,
    input  conv_pkg::addr_t tile_base_n,
    input  conv_pkg::addr_t tile_base_m,
    input  conv_pkg::addr_t tile_base_row,
    input  conv_pkg::addr_t tile_base_col,
    output conv_pkg::addr_t rd_addr,
    output logic            rd_en,
    input  conv_pkg::word_t rd_data,
    output logic            push,
    output conv_pkg::word_t push_data,
    input  logic            almost_full
);
    import conv_pkg::*;

    // loop bounds from outer to inner
    localparam int L0 = (KIND == LOAD_IN_FM) ? Tm : Tn;
    localparam int L1 = (KIND == LOAD_IN_FM) ? Tr + K - 1 : (KIND == LOAD_WEIGHT) ? Tm : Tr;
    localparam int L2 = (KIND == LOAD_IN_FM) ? Tc + K - 1 : (KIND == LOAD_WEIGHT) ? K : Tc;
    localparam int L3 = (KIND == LOAD_WEIGHT) ? K : 1;

    logic running;
    logic last_q;     // word returning next cycle is the final one
    logic w1, w2, w3;
    logic last_idx;
    int   c0, c1, c2, c3;

    assign w3       = (c3 == L3 - 1);
    assign w2       = (c2 == L2 - 1);
    assign w1       = (c1 == L1 - 1);
    assign last_idx = (c0 == L0 - 1) && w1 && w2 && w3;
    assign rd_en    = running && !almost_full;
    assign push_data = rd_data;

    always_comb begin
        case (KIND)
            LOAD_IN_FM:  rd_addr = addr_t'(((tile_base_m + c0) * (R + K - 1)
                                   + tile_base_row + c1) * (C + K - 1) + tile_base_col + c2);
            LOAD_WEIGHT: rd_addr = addr_t'(((tile_base_n + c0) * M + tile_base_m + c1) * K * K
                                   + c2 * K + c3);
            default:     rd_addr = addr_t'(((tile_base_n + c0) * R + tile_base_row + c1) * C
                                   + tile_base_col + c2);
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            push    <= 1'b0;
            last_q  <= 1'b0;
            done    <= 1'b0;
            c0 <= 0;
            c1 <= 0;
            c2 <= 0;
            c3 <= 0;
        end else begin
            push   <= rd_en;  // memory answers one cycle later
            last_q <= rd_en && last_idx;
            done   <= last_q;
            if (start) begin
                running <= 1'b1;
                c0 <= 0;
                c1 <= 0;
                c2 <= 0;
                c3 <= 0;
            end else if (rd_en) begin
                c3 <= w3 ? 0 : c3 + 1;
                if (w3) c2 <= w2 ? 0 : c2 + 1;
                if (w3 && w2) c1 <= w1 ? 0 : c1 + 1;
                if (w3 && w2 && w1) c0 <= last_idx ? 0 : c0 + 1;
                if (last_idx) running <= 1'b0;
            end
        end
    end

    // tile has to sit inside the layer
    a_tile_in_layer: assert property (@(posedge clk) disable iff (reset)
        start |-> (tile_base_n + Tn <= N) && (tile_base_m + Tm <= M)
               && (tile_base_row + Tr <= R) && (tile_base_col + Tc <= C))
        else $error("tile bases outside the layer");

endmodule

//--- logic/conv_core.sv
// ****************************************
// convolution compute core
// ****************************************
`timescale 1ns/100ps

module conv_core #(
    parameter int Tn         = 2,
    parameter int Tm         = 2,
    parameter int Tr         = 4,
    parameter int Tc         = 4,
    parameter int K          = 3,
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic            load_done_in,
    input  logic            load_done_w,
    input  logic            load_done_out,
    input  logic            in_push,
    input  conv_pkg::word_t in_push_data,
    output logic            in_almost_full,
    input  logic            w_push,
    input  conv_pkg::word_t w_push_data,
    output logic            w_almost_full,
    input  logic            out_push,
    input  conv_pkg::word_t out_push_data,
    output logic            out_almost_full,
    input  logic            st_pop,
    output conv_pkg::word_t st_data,
    output logic            st_empty,
    input  logic            store_done,
    output logic            busy
);
    import conv_pkg::*;

    localparam int IN_H = Tr + K - 1;
    localparam int IN_W = Tc + K - 1;

    core_state_e state;
    word_t in_buf  [Tm * IN_H * IN_W];
    word_t w_buf   [Tn * Tm * K * K];
    word_t out_buf [Tn * Tr * Tc];
    word_t in_dout, w_dout, out_dout, res_data;
    logic  in_empty, w_empty, out_empty;
    logic  in_pop, w_pop, out_pop;
    logic  [2:0] ld_seen;  // sticky loader done flags
    logic  res_almost_full, res_push, step;
    logic  wm, wkx, wky, wc, wr, tap_last, point_last;
    int    in_cnt, w_cnt, o_cnt;
    int    n, r, c, ky, kx, m;
    acc_t  acc, prod, sum;

    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_in_fifo (
        .clk, .reset, .push(in_push), .din(in_push_data), .pop(in_pop),
        .dout(in_dout), .almost_full(in_almost_full), .empty(in_empty));
    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_w_fifo (
        .clk, .reset, .push(w_push), .din(w_push_data), .pop(w_pop),
        .dout(w_dout), .almost_full(w_almost_full), .empty(w_empty));
    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_out_fifo (
        .clk, .reset, .push(out_push), .din(out_push_data), .pop(out_pop),
        .dout(out_dout), .almost_full(out_almost_full), .empty(out_empty));
    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_res_fifo (
        .clk, .reset, .push(res_push), .din(res_data), .pop(st_pop),
        .dout(st_data), .almost_full(res_almost_full), .empty(st_empty));

    // loaders walk in buffer order, so each fill is a plain counter
    assign in_pop  = (state == LOAD) && !in_empty;
    assign w_pop   = (state == LOAD) && !w_empty;
    assign out_pop = (state == LOAD) && !out_empty;

    always_ff @(posedge clk) begin
        if (in_pop)  in_buf[in_cnt] <= in_dout;
        if (w_pop)   w_buf[w_cnt]   <= w_dout;
        if (out_pop) out_buf[o_cnt] <= out_dout;
    end

    // n, r, c outer loops, then ky, kx, m inner
    assign wm         = (m == Tm - 1);
    assign wkx        = (kx == K - 1);
    assign wky        = (ky == K - 1);
    assign wc         = (c == Tc - 1);
    assign wr         = (r == Tr - 1);
    assign tap_last   = wm && wkx && wky;
    assign point_last = tap_last && wc && wr && (n == Tn - 1);
    assign step       = (state == COMPUTE) && !res_almost_full;  // stall on result back-pressure
    assign res_push   = step && tap_last;

    assign prod     = acc_t'(in_buf[(m * IN_H + r + ky) * IN_W + c + kx])
                    * acc_t'(w_buf[((n * Tm + m) * K + ky) * K + kx]);
    assign sum      = acc + prod;
    assign res_data = word_t'(acc_t'(out_buf[(n * Tr + r) * Tc + c]) + sum);  // low 16 bits
    assign busy     = (state != IDLE);

    always_ff @(posedge clk) begin
        if (reset || start) begin
            ld_seen <= '0;
            in_cnt <= 0;
            w_cnt  <= 0;
            o_cnt  <= 0;
            acc <= '0;
            n  <= 0;
            r  <= 0;
            c  <= 0;
            ky <= 0;
            kx <= 0;
            m  <= 0;
        end else begin
            ld_seen <= ld_seen | {load_done_out, load_done_w, load_done_in};
            if (in_pop)  in_cnt <= in_cnt + 1;
            if (w_pop)   w_cnt  <= w_cnt + 1;
            if (out_pop) o_cnt  <= o_cnt + 1;
            if (step) begin
                acc <= tap_last ? '0 : sum;
                m <= wm ? 0 : m + 1;
                if (wm) kx <= wkx ? 0 : kx + 1;
                if (wm && wkx) ky <= wky ? 0 : ky + 1;
                if (tap_last) c <= wc ? 0 : c + 1;
                if (tap_last && wc) r <= wr ? 0 : r + 1;
                if (tap_last && wc && wr) n <= point_last ? 0 : n + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (start) state <= LOAD;
                LOAD:    if (&ld_seen && in_empty && w_empty && out_empty) state <= COMPUTE;
                COMPUTE: if (step && point_last) state <= DRAIN;
                DRAIN:   if (store_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // store unit may only finish after the last result has been queued
    a_store_done_in_drain: assert property (@(posedge clk) disable iff (reset)
        store_done |-> (state == DRAIN))
        else $error("store_done arrived while the core was not draining");

endmodule

//--- logic/out_fm_store.sv
// ****************************************
// output tile store
// ****************************************
`timescale 1ns/100ps

module out_fm_store #(
    parameter int N  = 4,
    parameter int R  = 8,
    parameter int C  = 8,
    parameter int Tn = 2,
    parameter int Tr = 4,
    parameter int Tc = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    output logic            done,
    input  conv_pkg::addr_t tile_base_n,
    input  conv_pkg::addr_t tile_base_row,
    input  conv_pkg::addr_t tile_base_col,
    output logic            pop,
    input  conv_pkg::word_t data,
    input  logic            empty,
    output conv_pkg::addr_t wr_addr,
    output conv_pkg::word_t wr_data,
    output logic            wr_en
);
    import conv_pkg::*;

    logic running;
    logic last_q;
    logic wc, wr, last_idx;
    int   n, r, c;

    assign wc       = (c == Tc - 1);
    assign wr       = (r == Tr - 1);
    assign last_idx = (n == Tn - 1) && wr && wc;
    assign pop      = running && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            wr_en   <= 1'b0;
            last_q  <= 1'b0;
            done    <= 1'b0;
            n <= 0;
            r <= 0;
            c <= 0;
        end else begin
            wr_en  <= pop;  // popped word goes out next cycle
            last_q <= pop && last_idx;
            done   <= last_q;
            if (start) begin
                running <= 1'b1;
                n <= 0;
                r <= 0;
                c <= 0;
            end else if (pop) begin
                c <= wc ? 0 : c + 1;
                if (wc) r <= wr ? 0 : r + 1;
                if (wc && wr) n <= last_idx ? 0 : n + 1;
                if (last_idx) running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            wr_data <= data;
            wr_addr <= addr_t'(((tile_base_n + n) * R + tile_base_row + r) * C + tile_base_col + c);
        end
    end

    a_store_in_layer: assert property (@(posedge clk) disable iff (reset)
        start |-> (tile_base_n + Tn <= N) && (tile_base_row + Tr <= R)
               && (tile_base_col + Tc <= C))
        else $error("store tile outside the output map");

endmodule

//--- logic/conv_tile.sv
// ****************************************
// convolution tile engine top
// ****************************************
`timescale 1ns/100ps

module conv_tile #(
    parameter int N          = 4,
    parameter int M          = 4,
    parameter int R          = 8,
    parameter int C          = 8,
    parameter int Tn         = 2,
    parameter int Tm         = 2,
    parameter int Tr         = 4,
    parameter int Tc         = 4,
    parameter int K          = 3,
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            conv_tile_start,
    output logic            conv_tile_done,
    input  conv_pkg::addr_t tile_base_n,
    input  conv_pkg::addr_t tile_base_m,
    input  conv_pkg::addr_t tile_base_row,
    input  conv_pkg::addr_t tile_base_col,
    output conv_pkg::addr_t in_fm_rd_addr,
    output logic            in_fm_rd_en,
    input  conv_pkg::word_t in_fm_rd_data,
    output conv_pkg::addr_t weight_rd_addr,
    output logic            weight_rd_en,
    input  conv_pkg::word_t weight_rd_data,
    output conv_pkg::addr_t out_fm_rd_addr,
    output logic            out_fm_rd_en,
    input  conv_pkg::word_t out_fm_rd_data,
    output conv_pkg::addr_t out_fm_wr_addr,
    output conv_pkg::word_t out_fm_wr_data,
    output logic            out_fm_wr_en
);
    import conv_pkg::*;

    logic  start_ok;  // start only counts while the core is idle
    logic  core_busy;
    logic  done_in, done_w, done_out;
    logic  in_push, w_push, out_push;
    logic  in_af, w_af, out_af;
    word_t in_data, w_data, out_data, st_data;
    logic  st_pop, st_empty;

    assign start_ok = conv_tile_start && !core_busy;

    tile_loader #(.KIND(LOAD_IN_FM), .N(N), .M(M), .R(R), .C(C),
                  .Tn(Tn), .Tm(Tm), .Tr(Tr), .Tc(Tc), .K(K)) u_in_loader (
        .clk, .reset, .start(start_ok), .done(done_in),
        .tile_base_n, .tile_base_m, .tile_base_row, .tile_base_col,
        .rd_addr(in_fm_rd_addr), .rd_en(in_fm_rd_en), .rd_data(in_fm_rd_data),
        .push(in_push), .push_data(in_data), .almost_full(in_af));

    tile_loader #(.KIND(LOAD_WEIGHT), .N(N), .M(M), .R(R), .C(C),
                  .Tn(Tn), .Tm(Tm), .Tr(Tr), .Tc(Tc), .K(K)) u_w_loader (
        .clk, .reset, .start(start_ok), .done(done_w),
        .tile_base_n, .tile_base_m, .tile_base_row, .tile_base_col,
        .rd_addr(weight_rd_addr), .rd_en(weight_rd_en), .rd_data(weight_rd_data),
        .push(w_push), .push_data(w_data), .almost_full(w_af));

    tile_loader #(.KIND(LOAD_OUT_FM), .N(N), .M(M), .R(R), .C(C),
                  .Tn(Tn), .Tm(Tm), .Tr(Tr), .Tc(Tc), .K(K)) u_out_loader (
        .clk, .reset, .start(start_ok), .done(done_out),
        .tile_base_n, .tile_base_m, .tile_base_row, .tile_base_col,
        .rd_addr(out_fm_rd_addr), .rd_en(out_fm_rd_en), .rd_data(out_fm_rd_data),
        .push(out_push), .push_data(out_data), .almost_full(out_af));

    conv_core #(.Tn(Tn), .Tm(Tm), .Tr(Tr), .Tc(Tc), .K(K),
                .FIFO_DEPTH(FIFO_DEPTH)) u_core (
        .clk, .reset, .start(start_ok),
        .load_done_in(done_in), .load_done_w(done_w), .load_done_out(done_out),
        .in_push, .in_push_data(in_data), .in_almost_full(in_af),
        .w_push, .w_push_data(w_data), .w_almost_full(w_af),
        .out_push, .out_push_data(out_data), .out_almost_full(out_af),
        .st_pop, .st_data, .st_empty, .store_done(conv_tile_done), .busy(core_busy));

    // store runs alongside compute, the result fifo is far shallower than a tile
    out_fm_store #(.N(N), .R(R), .C(C), .Tn(Tn), .Tr(Tr), .Tc(Tc)) u_store (
        .clk, .reset, .start(start_ok), .done(conv_tile_done),
        .tile_base_n, .tile_base_row, .tile_base_col,
        .pop(st_pop), .data(st_data), .empty(st_empty),
        .wr_addr(out_fm_wr_addr), .wr_data(out_fm_wr_data), .wr_en(out_fm_wr_en));

endmodule

//--- dv/conv_ref_model.svh
// ****************************************
// convolution reference model
// ****************************************
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

// input map, channel planes padded by K-1 rows and columns
function automatic int in_addr(int m, int y, int x);
    return (m * (R + K - 1) + y) * (C + K - 1) + x;
endfunction

function automatic int w_addr(int n, int m, int ky, int kx);
    return (n * M + m) * K * K + ky * K + kx;
endfunction

function automatic int out_addr(int n, int r, int c);
    return (n * R + r) * C + c;
endfunction

// one output point: old partial plus the kernel sum over the tile's input channels
function automatic word_t ref_point(int n, int r, int c, int m_base, word_t partial);
    acc_t acc;
    acc = acc_t'(partial);
    for (int m = m_base; m < m_base + Tm; m++) begin
        for (int ky = 0; ky < K; ky++) begin
            for (int kx = 0; kx < K; kx++) begin
                acc += acc_t'(in_mem[in_addr(m, r + ky, c + kx)])
                     * acc_t'(w_mem[w_addr(n, m, ky, kx)]);  // wraps at 32 bits
            end
        end
    end
    return word_t'(acc);  // stored word keeps the low 16 bits
endfunction

`endif

//--- dv/conv_tile_tb.sv
// ****************************************
// conv tile engine testbench
// ****************************************
`timescale 1ns/100ps

module conv_tile_tb;
    import conv_pkg::*;

    localparam int N = 4;
    localparam int M = 4;
    localparam int R = 8;
    localparam int C = 8;
    localparam int Tn = 2;
    localparam int Tm = 2;
    localparam int Tr = 4;
    localparam int Tc = 4;
    localparam int K = 3;
    localparam int FIFO_DEPTH = 4;
    localparam int IN_SIZE = M * (R + K - 1) * (C + K - 1);
    localparam int W_SIZE = N * M * K * K;
    localparam int OUT_SIZE = N * R * C;
    localparam int NUM_TESTS = 7;
    localparam int TIMEOUT = 5000;  // cycles per tile

    logic  clk;
    logic  reset;
    logic  conv_tile_start;
    logic  conv_tile_done;
    addr_t tile_base_n, tile_base_m, tile_base_row, tile_base_col;
    addr_t in_fm_rd_addr, weight_rd_addr, out_fm_rd_addr, out_fm_wr_addr;
    logic  in_fm_rd_en, weight_rd_en, out_fm_rd_en, out_fm_wr_en;
    word_t in_fm_rd_data = '0;
    word_t weight_rd_data = '0;
    word_t out_fm_rd_data = '0;
    word_t out_fm_wr_data;

    word_t in_mem  [IN_SIZE];
    word_t w_mem   [W_SIZE];
    word_t out_mem [OUT_SIZE];  // output map, read as partials and written by the DUT
    word_t exp_out [OUT_SIZE];
    bit    written [OUT_SIZE];
    logic [31:0] rng;
    int    errors, fails, tests_run, writes;
    bit    timed_out;

    // test table: name, tile bases n/m/row/col, full-range data refill
    string tname   [NUM_TESTS] = '{"zero_base", "accumulate", "offset_all", "offset_m_col",
                                   "offset_n_row", "wrap_large", "after_wrap"};
    int    row_n   [NUM_TESTS] = '{0, 0, 2, 0, 2, 2, 0};
    int    row_m   [NUM_TESTS] = '{0, 0, 2, 2, 0, 2, 0};
    int    row_r   [NUM_TESTS] = '{0, 0, 4, 0, 4, 0, 4};
    int    row_c   [NUM_TESTS] = '{0, 0, 4, 4, 0, 4, 0};
    bit    row_big [NUM_TESTS] = '{0, 0, 0, 0, 0, 1, 0};

    `include "conv_ref_model.svh"

    conv_tile #(.N(N), .M(M), .R(R), .C(C), .Tn(Tn), .Tm(Tm), .Tr(Tr), .Tc(Tc), .K(K),
                .FIFO_DEPTH(FIFO_DEPTH)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // read ports answer one cycle after rd_en
    always @(posedge clk) begin
        if (in_fm_rd_en) in_fm_rd_data <= in_mem[int'(in_fm_rd_addr)];
        if (weight_rd_en) weight_rd_data <= w_mem[int'(weight_rd_addr)];
        if (out_fm_rd_en) out_fm_rd_data <= out_mem[int'(out_fm_rd_addr)];
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t sample_value(logic [31:0] x, bit big);
        if (big) return word_t'(x[15:0]);
        return word_t'(int'(x % 32'd129) - 64);  // -64 .. 64
    endfunction

    task automatic fill_memories(input bit big);
        for (int a = 0; a < IN_SIZE; a++) begin
            rng = xorshift(rng);
            in_mem[a] = sample_value(rng, big);
        end
        for (int a = 0; a < W_SIZE; a++) begin
            rng = xorshift(rng);
            w_mem[a] = sample_value(rng, big);
        end
        for (int a = 0; a < OUT_SIZE; a++) begin
            rng = xorshift(rng);
            out_mem[a] = sample_value(rng, big);
            exp_out[a] = out_mem[a];
        end
    endtask

    task automatic apply_reference(input int n0, input int m0, input int r0, input int c0);
        int a;
        for (int n = 0; n < Tn; n++)
            for (int r = 0; r < Tr; r++)
                for (int c = 0; c < Tc; c++) begin
                    a = out_addr(n0 + n, r0 + r, c0 + c);
                    exp_out[a] = ref_point(n0 + n, r0 + r, c0 + c, m0, exp_out[a]);
                end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %b actual %b", name, expected, actual);
        end
    endtask

    // sampled 2 ns after the edge, once the registered write port has settled
    task automatic record_write(input string name);
        int a;
        if (out_fm_wr_en) begin
            a = int'(out_fm_wr_addr);
            writes++;
            if (a >= OUT_SIZE) begin
                errors++;
                $display("test %s wrote outside the output map at address %0d", name, a);
            end else begin
                if (written[a]) begin
                    errors++;
                    $display("test %s wrote address %0d more than once", name, a);
                end
                written[a] = 1'b1;
                out_mem[a] = out_fm_wr_data;
            end
        end
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        while (conv_tile_done !== 1'b1 && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            record_write(name);
            cycles++;
        end
        if (conv_tile_done !== 1'b1) begin
            timed_out = 1'b1;
            $display("test %s got no conv_tile_done within %0d cycles", name, TIMEOUT);
        end
    endtask

    task automatic run_test(input int t);
        int    err_before;
        int    done_writes;
        string name;
        err_before = errors;
        name = tname[t];
        if (row_big[t]) fill_memories(1'b1);
        apply_reference(row_n[t], row_m[t], row_r[t], row_c[t]);
        for (int a = 0; a < OUT_SIZE; a++) written[a] = 1'b0;
        writes = 0;
        tile_base_n = addr_t'(row_n[t]);
        tile_base_m = addr_t'(row_m[t]);
        tile_base_row = addr_t'(row_r[t]);
        tile_base_col = addr_t'(row_c[t]);
        conv_tile_start = 1'b1;
        @(posedge clk);
        #2;
        conv_tile_start = 1'b0;
        wait_done(name);
        if (!timed_out) begin
            done_writes = writes;
            @(posedge clk);  // done must drop and no write may follow it
            #2;
            record_write(name);
            check_flag({name, " done pulse"}, 1'b0, conv_tile_done);
            check_count({name, " writes after done"}, done_writes, writes);
            check_count({name, " writes"}, Tn * Tr * Tc, done_writes);
            for (int a = 0; a < OUT_SIZE; a++)
                check_word($sformatf("%s out[%0d]", name, a), exp_out[a], out_mem[a]);
        end
        tests_run++;
        if (errors == err_before && !timed_out) begin
            $display("test %s passed", name);
        end else begin
            fails++;
            $display("test %s failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        reset = 1'b1;
        conv_tile_start = 1'b0;
        tile_base_n = '0;
        tile_base_m = '0;
        tile_base_row = '0;
        tile_base_col = '0;
        rng = 32'hb1e;
        errors = 0;
        fails = 0;
        tests_run = 0;
        writes = 0;
        timed_out = 1'b0;
        fill_memories(1'b0);
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #2;
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) run_test(t);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, fails, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+dv
logic/conv_pkg.sv
logic/sync_fifo.sv
logic/tile_loader.sv
logic/conv_core.sv
logic/out_fm_store.sv
logic/conv_tile.sv
dv/conv_tile_tb.sv

//--- run.sh
#!/bin/sh
# build the conv tile testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module conv_tile_tb -o conv_tile_sim
./obj_dir/conv_tile_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
